// ==== common/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Address of the first instruction fetched after reset
`define MIPS_PC_INIT 32'h0000_0000

// Architectural register count
`define MIPS_NREGS 32

`endif

// ==== common/mips_types_pkg.sv ====
`default_nettype none

package mips_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluop_t;

  typedef enum logic [1:0] {RFIN_ALU, RFIN_RAM, RFIN_NPC, RFIN_LUI} rfin_sel_t;
  typedef enum logic [1:0] {ALUB_RDAT, ALUB_EXT, ALUB_SHAMT} alub_sel_t;
  typedef enum logic [1:0] {PC_NPC, PC_BR, PC_JMP, PC_REG} pc_sel_t;
  typedef enum logic {SEL_STD, SEL_FWD} fwd_sel_t;

  typedef struct packed {
    aluop_t    aluop;
    alub_sel_t alub_sel;
    logic      wen;
    rfin_sel_t rfin_sel;
    regbits_t  wsel;
    logic      dread;
    logic      dwrite;
    logic      halt;
    logic      bne;
    logic      sign_ext;
    pc_sel_t   pc_sel;
    logic      is_branch;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t npc;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    npc;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    regbits_t rs;
    regbits_t rt;
    regbits_t shamt;
  } id_ex_t;

  // dload is filled in place when the data memory answers
  typedef struct packed {
    ctrl_t ctrl;
    word_t result;
    word_t store;
    word_t dload;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t ctrl;
    word_t result;
    word_t dload;
  } mem_wb_t;

  typedef struct packed {
    word_t iaddr;
    word_t daddr;
    word_t dstore;
    logic  dread;
    logic  dwrite;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== datapath/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_macros.svh"

module datapath (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     ihit_i,
  input  logic                     dhit_i,
  input  mips_types_pkg::word_t    imemload_i,
  input  mips_types_pkg::word_t    dmemload_i,
  output mips_types_pkg::mem_req_t req_o,
  output logic                     halt_o
);

  mips_types_pkg::word_t    pc, pc4, next_pc, br_target, jmp_target;
  mips_types_pkg::if_id_t   if_id;
  mips_types_pkg::id_ex_t   id_ex, id_ex_next;
  mips_types_pkg::ex_mem_t  ex_mem;
  mips_types_pkg::mem_wb_t  mem_wb;
  mips_types_pkg::ctrl_t    id_ctrl;
  mips_types_pkg::regbits_t id_rs, id_rt;
  mips_types_pkg::word_t    id_imm, rdat1, rdat2, br_a, br_b, br_fwd;
  mips_types_pkg::fwd_sel_t a_sel, b_sel, br_rs_sel, br_rt_sel;
  mips_types_pkg::word_t    a_fwd, b_fwd, alu_a, alu_b, ex_b, alu_out, ex_result, wb_dat;
  logic redirect, stall, mem_busy, mem_load, adv;

  // Whole pipeline waits on an outstanding data access
  assign mem_busy = ex_mem.ctrl.dread | ex_mem.ctrl.dwrite;
  assign adv      = ihit_i & ~mem_busy;
  assign mem_load = (ex_mem.ctrl.rfin_sel == mips_types_pkg::RFIN_RAM);

  // Fetch
  assign pc4 = pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc    <= `MIPS_PC_INIT;
      if_id <= '0;
    end else if (adv && !stall) begin
      pc    <= next_pc;
      if_id <= redirect ? '0 : '{instr: imemload_i, npc: pc4};
    end
  end

  // Decode, branches and jumps resolve here
  decode_unit decode_unit_i (
    .instr_i(if_id.instr), .ctrl_o(id_ctrl), .rsel1_o(id_rs), .rsel2_o(id_rt), .imm_o(id_imm)
  );

  register_file register_file_i (
    .CLK, .nRST, .wen_i(mem_wb.ctrl.wen), .wsel_i(mem_wb.ctrl.wsel), .wdat_i(wb_dat),
    .rsel1_i(id_rs), .rsel2_i(id_rt), .rdat1_o(rdat1), .rdat2_o(rdat2)
  );

  hazard_unit hazard_unit_i (
    .id_rs_i(id_rs), .id_rt_i(id_rt), .id_is_branch_i(id_ctrl.is_branch),
    .ex_dread_i(id_ex.ctrl.dread), .ex_wen_i(id_ex.ctrl.wen), .ex_dest_i(id_ex.ctrl.wsel),
    .mem_dread_i(mem_load), .mem_dest_i(ex_mem.ctrl.wsel), .stall_o(stall)
  );

  assign br_a       = (br_rs_sel == mips_types_pkg::SEL_FWD) ? br_fwd : rdat1;
  assign br_b       = (br_rt_sel == mips_types_pkg::SEL_FWD) ? br_fwd : rdat2;
  assign br_target  = if_id.npc + {id_imm[29:0], 2'b00};
  assign jmp_target = {if_id.npc[31:28], if_id.instr[25:0], 2'b00};

  always_comb begin
    case (id_ctrl.pc_sel)
      mips_types_pkg::PC_BR:  redirect = id_ctrl.halt | ((br_a == br_b) ^ id_ctrl.bne);
      mips_types_pkg::PC_NPC: redirect = 1'b0;
      default:                redirect = 1'b1;
    endcase
    case (id_ctrl.pc_sel)
      mips_types_pkg::PC_BR:  next_pc = redirect ? br_target : pc4;
      mips_types_pkg::PC_JMP: next_pc = jmp_target;
      mips_types_pkg::PC_REG: next_pc = br_a;
      default:                next_pc = pc4;
    endcase
  end

  assign id_ex_next = '{ctrl: id_ctrl, npc: if_id.npc, rdat1: rdat1, rdat2: rdat2,
                        imm: id_imm, rs: id_rs, rt: id_rt, shamt: if_id.instr[10:6]};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex <= '0;
    end else if (adv) begin
      id_ex <= stall ? '0 : id_ex_next;
    end
  end

  // Execute
  forwarding_unit forwarding_unit_i (
    .id_rs_i(id_rs), .id_rt_i(id_rt), .ex_rs_i(id_ex.rs), .ex_rt_i(id_ex.rt),
    .mem_wen_i(ex_mem.ctrl.wen && !mem_load), .mem_dest_i(ex_mem.ctrl.wsel),
    .mem_val_i(ex_mem.result), .wb_wen_i(mem_wb.ctrl.wen), .wb_dest_i(mem_wb.ctrl.wsel),
    .wb_val_i(wb_dat), .a_sel_o(a_sel), .b_sel_o(b_sel), .a_val_o(a_fwd), .b_val_o(b_fwd),
    .br_rs_sel_o(br_rs_sel), .br_rt_sel_o(br_rt_sel), .br_val_o(br_fwd)
  );

  assign alu_a = (a_sel == mips_types_pkg::SEL_FWD) ? a_fwd : id_ex.rdat1;
  assign ex_b  = (b_sel == mips_types_pkg::SEL_FWD) ? b_fwd : id_ex.rdat2;

  always_comb begin
    case (id_ex.ctrl.alub_sel)
      mips_types_pkg::ALUB_EXT:   alu_b = id_ex.imm;
      mips_types_pkg::ALUB_SHAMT: alu_b = {27'd0, id_ex.shamt};
      default:                    alu_b = ex_b;
    endcase
    case (id_ex.ctrl.rfin_sel)
      mips_types_pkg::RFIN_NPC: ex_result = id_ex.npc;
      mips_types_pkg::RFIN_LUI: ex_result = {id_ex.imm[15:0], 16'd0};
      default:                  ex_result = alu_out;
    endcase
  end

  alu alu_i (.op_i(id_ex.ctrl.aluop), .a_i(alu_a), .b_i(alu_b), .out_o(alu_out), .zero_o());

  // Memory, enables drop once dhit has returned the data
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem <= '0;
    end else if (adv) begin
      ex_mem.ctrl   <= id_ex.ctrl;
      ex_mem.result <= ex_result;
      ex_mem.store  <= ex_b;
    end else if (dhit_i && mem_busy) begin
      ex_mem.ctrl.dread  <= 1'b0;
      ex_mem.ctrl.dwrite <= 1'b0;
      ex_mem.dload       <= dmemload_i;
    end
  end

  // Enables are those of the instruction entering the memory stage
  assign req_o.iaddr  = pc;
  assign req_o.daddr  = ex_mem.result;
  assign req_o.dstore = ex_mem.store;
  assign req_o.dread  = id_ex.ctrl.dread;
  assign req_o.dwrite = id_ex.ctrl.dwrite;

  // Writeback
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_wb <= '0;
    end else if (adv) begin
      mem_wb <= '{ctrl: ex_mem.ctrl, result: ex_mem.result, dload: ex_mem.dload};
    end
  end

  assign wb_dat = (mem_wb.ctrl.rfin_sel == mips_types_pkg::RFIN_RAM) ? mem_wb.dload :
                                                                       mem_wb.result;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt_o <= 1'b0;
    end else if (mem_wb.ctrl.halt) begin
      halt_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  mips_types_pkg::aluop_t op_i,
  input  mips_types_pkg::word_t  a_i,
  input  mips_types_pkg::word_t  b_i,
  output mips_types_pkg::word_t  out_o,
  output logic                   zero_o
);

  always_comb begin
    case (op_i)
      mips_types_pkg::ALU_SLL: out_o = a_i << b_i[4:0];
      mips_types_pkg::ALU_ADD: out_o = a_i + b_i;
      mips_types_pkg::ALU_SUB: out_o = a_i - b_i;
      mips_types_pkg::ALU_AND: out_o = a_i & b_i;
      mips_types_pkg::ALU_OR:  out_o = a_i | b_i;
      // Signed compare
      mips_types_pkg::ALU_SLT: out_o = {31'd0, $signed(a_i) < $signed(b_i)};
      default:                 out_o = '0;
    endcase
  end

  assign zero_o = (out_o == '0);

endmodule

`default_nettype wire

// ==== hw/decode_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
  input  mips_types_pkg::word_t    instr_i,
  output mips_types_pkg::ctrl_t    ctrl_o,
  output mips_types_pkg::regbits_t rsel1_o,
  output mips_types_pkg::regbits_t rsel2_o,
  output mips_types_pkg::word_t    imm_o
);

  logic [5:0] opcode;
  logic [5:0] funct;
  mips_types_pkg::regbits_t rs;
  mips_types_pkg::regbits_t rt;
  mips_types_pkg::regbits_t rd;

  assign opcode = instr_i[31:26];
  assign funct  = instr_i[5:0];
  assign rs     = instr_i[25:21];
  assign rt     = instr_i[20:16];
  assign rd     = instr_i[15:11];

  always_comb begin
    ctrl_o       = '0;
    ctrl_o.aluop = mips_types_pkg::ALU_ADD;
    rsel1_o      = rs;
    rsel2_o      = rt;
    case (opcode)
      6'h00: begin
        ctrl_o.wen  = 1'b1;
        ctrl_o.wsel = rd;
        case (funct)
          6'h00: begin
            // SLL shifts rt, so rt goes on the A side
            ctrl_o.aluop    = mips_types_pkg::ALU_SLL;
            ctrl_o.alub_sel = mips_types_pkg::ALUB_SHAMT;
            rsel1_o         = rt;
          end
          6'h21: ctrl_o.aluop = mips_types_pkg::ALU_ADD;
          6'h23: ctrl_o.aluop = mips_types_pkg::ALU_SUB;
          6'h24: ctrl_o.aluop = mips_types_pkg::ALU_AND;
          6'h25: ctrl_o.aluop = mips_types_pkg::ALU_OR;
          6'h2a: ctrl_o.aluop = mips_types_pkg::ALU_SLT;
          6'h08: begin
            ctrl_o.wen       = 1'b0;
            ctrl_o.pc_sel    = mips_types_pkg::PC_REG;
            ctrl_o.is_branch = 1'b1;
          end
          default: ctrl_o.wen = 1'b0;
        endcase
      end
      6'h09, 6'h0d, 6'h0f, 6'h23: begin
        ctrl_o.alub_sel = mips_types_pkg::ALUB_EXT;
        ctrl_o.wen      = 1'b1;
        ctrl_o.wsel     = rt;
        ctrl_o.sign_ext = (opcode == 6'h09) || (opcode == 6'h23);
        if (opcode == 6'h0d) begin
          ctrl_o.aluop = mips_types_pkg::ALU_OR;
        end
        if (opcode == 6'h0f) begin
          ctrl_o.rfin_sel = mips_types_pkg::RFIN_LUI;
        end
        if (opcode == 6'h23) begin
          ctrl_o.rfin_sel = mips_types_pkg::RFIN_RAM;
          ctrl_o.dread    = 1'b1;
        end
      end
      6'h2b: begin
        ctrl_o.alub_sel = mips_types_pkg::ALUB_EXT;
        ctrl_o.sign_ext = 1'b1;
        ctrl_o.dwrite   = 1'b1;
      end
      6'h04, 6'h05: begin
        ctrl_o.pc_sel    = mips_types_pkg::PC_BR;
        ctrl_o.is_branch = 1'b1;
        ctrl_o.sign_ext  = 1'b1;
        ctrl_o.bne       = opcode[0];
      end
      6'h02, 6'h03: begin
        ctrl_o.pc_sel = mips_types_pkg::PC_JMP;
        if (opcode[0]) begin
          ctrl_o.wen      = 1'b1;
          ctrl_o.wsel     = 5'd31;
          ctrl_o.rfin_sel = mips_types_pkg::RFIN_NPC;
        end
      end
      // HALT is a taken branch back onto itself
      6'h3f: begin
        ctrl_o.halt   = 1'b1;
        ctrl_o.pc_sel = mips_types_pkg::PC_BR;
      end
      default: ;
    endcase
  end

  assign imm_o = ctrl_o.halt     ? '1 :
                 ctrl_o.sign_ext ? {{16{instr_i[15]}}, instr_i[15:0]} :
                                   {16'd0, instr_i[15:0]};

endmodule

`default_nettype wire

// ==== hw/forwarding_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit (
  input  mips_types_pkg::regbits_t id_rs_i,
  input  mips_types_pkg::regbits_t id_rt_i,
  input  mips_types_pkg::regbits_t ex_rs_i,
  input  mips_types_pkg::regbits_t ex_rt_i,
  input  logic                     mem_wen_i,
  input  mips_types_pkg::regbits_t mem_dest_i,
  input  mips_types_pkg::word_t    mem_val_i,
  input  logic                     wb_wen_i,
  input  mips_types_pkg::regbits_t wb_dest_i,
  input  mips_types_pkg::word_t    wb_val_i,
  output mips_types_pkg::fwd_sel_t a_sel_o,
  output mips_types_pkg::fwd_sel_t b_sel_o,
  output mips_types_pkg::word_t    a_val_o,
  output mips_types_pkg::word_t    b_val_o,
  output mips_types_pkg::fwd_sel_t br_rs_sel_o,
  output mips_types_pkg::fwd_sel_t br_rt_sel_o,
  output mips_types_pkg::word_t    br_val_o
);

  logic a_mem, a_wb, b_mem, b_wb;

  function automatic logic match(input logic wen, input mips_types_pkg::regbits_t dest,
                                 input mips_types_pkg::regbits_t src);
    return wen && dest != '0 && dest == src;
  endfunction

  assign a_mem = match(mem_wen_i, mem_dest_i, ex_rs_i);
  assign b_mem = match(mem_wen_i, mem_dest_i, ex_rt_i);
  assign a_wb  = match(wb_wen_i, wb_dest_i, ex_rs_i);
  assign b_wb  = match(wb_wen_i, wb_dest_i, ex_rt_i);

  // Youngest result wins
  assign a_sel_o = (a_mem || a_wb) ? mips_types_pkg::SEL_FWD : mips_types_pkg::SEL_STD;
  assign b_sel_o = (b_mem || b_wb) ? mips_types_pkg::SEL_FWD : mips_types_pkg::SEL_STD;
  assign a_val_o = a_mem ? mem_val_i : wb_val_i;
  assign b_val_o = b_mem ? mem_val_i : wb_val_i;

  // Branch compare in decode, writeback is already visible in the register file
  assign br_rs_sel_o = match(mem_wen_i, mem_dest_i, id_rs_i) ? mips_types_pkg::SEL_FWD :
                                                                mips_types_pkg::SEL_STD;
  assign br_rt_sel_o = match(mem_wen_i, mem_dest_i, id_rt_i) ? mips_types_pkg::SEL_FWD :
                                                                mips_types_pkg::SEL_STD;
  assign br_val_o    = mem_val_i;

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  input  mips_types_pkg::regbits_t id_rs_i,
  input  mips_types_pkg::regbits_t id_rt_i,
  input  logic                     id_is_branch_i,
  input  logic                     ex_dread_i,
  input  logic                     ex_wen_i,
  input  mips_types_pkg::regbits_t ex_dest_i,
  input  logic                     mem_dread_i,
  input  mips_types_pkg::regbits_t mem_dest_i,
  output logic                     stall_o
);

  logic ex_dep, mem_dep;

  assign ex_dep  = ex_wen_i && ex_dest_i != '0 &&
                   (ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);
  assign mem_dep = mem_dread_i && mem_dest_i != '0 &&
                   (mem_dest_i == id_rs_i || mem_dest_i == id_rt_i);

  // Load-use, or a branch whose operand is not yet available
  assign stall_o = (ex_dep && (ex_dread_i || id_is_branch_i)) ||
                   (mem_dep && id_is_branch_i);

endmodule

`default_nettype wire

// ==== hw/mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_core (
  input  logic                  CLK,
  input  logic                  nRST,
  input  mips_types_pkg::word_t imemload_i,
  input  logic                  ihit_i,
  input  mips_types_pkg::word_t dmemload_i,
  input  logic                  dhit_i,
  output mips_types_pkg::word_t imemaddr_o,
  output mips_types_pkg::word_t dmemaddr_o,
  output mips_types_pkg::word_t dmemstore_o,
  output logic                  dmemren_o,
  output logic                  dmemwen_o,
  output logic                  halt_o
);

  mips_types_pkg::mem_req_t req;

  datapath datapath_i (
    .CLK, .nRST, .ihit_i, .dhit_i, .imemload_i, .dmemload_i, .req_o(req), .halt_o
  );

  request_unit request_unit_i (
    .CLK, .nRST, .ihit_i, .dhit_i, .dread_i(req.dread), .dwrite_i(req.dwrite),
    .dmemren_o, .dmemwen_o
  );

  assign imemaddr_o  = req.iaddr;
  assign dmemaddr_o  = req.daddr;
  assign dmemstore_o = req.dstore;

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_macros.svh"

module register_file (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     wen_i,
  input  mips_types_pkg::regbits_t wsel_i,
  input  mips_types_pkg::word_t    wdat_i,
  input  mips_types_pkg::regbits_t rsel1_i,
  input  mips_types_pkg::regbits_t rsel2_i,
  output mips_types_pkg::word_t    rdat1_o,
  output mips_types_pkg::word_t    rdat2_o
);

  mips_types_pkg::word_t regs [`MIPS_NREGS];

  // Falling edge write, decode reads the new value in the same cycle
  always_ff @(negedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && wsel_i != '0) begin
      regs[wsel_i] <= wdat_i;
    end
  end

  assign rdat1_o = regs[rsel1_i];
  assign rdat2_o = regs[rsel2_i];

endmodule

`default_nettype wire

// ==== hw/request_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module request_unit (
  input  logic CLK,
  input  logic nRST,
  input  logic ihit_i,
  input  logic dhit_i,
  input  logic dread_i,
  input  logic dwrite_i,
  output logic dmemren_o,
  output logic dmemwen_o
);

  // The memory stage only advances while no access is outstanding
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dmemren_o <= 1'b0;
      dmemwen_o <= 1'b0;
    end else if (dhit_i) begin
      dmemren_o <= 1'b0;
      dmemwen_o <= 1'b0;
    end else if (ihit_i && !dmemren_o && !dmemwen_o) begin
      dmemren_o <= dread_i;
      dmemwen_o <= dwrite_i;
    end
  end

endmodule

`default_nettype wire

// ==== mips_core.f ====
+incdir+common
common/mips_types_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/decode_unit.sv
hw/forwarding_unit.sv
hw/hazard_unit.sv
hw/request_unit.sv
datapath/datapath.sv
hw/mips_core.sv
sim/mips_checker.sv
sim/tb_mips_core.sv

// ==== sim/mips_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_checker (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dmemwen_i,
  input  logic                  dmemren_i,
  input  logic                  dhit_i,
  input  mips_types_pkg::word_t imemaddr_i,
  input  mips_types_pkg::word_t dmemaddr_i,
  input  mips_types_pkg::word_t dmemstore_i,
  input  logic                  halt_i
);

  mips_types_pkg::word_t got_addr [$];
  mips_types_pkg::word_t got_data [$];
  mips_types_pkg::word_t exp_addr [$];
  mips_types_pkg::word_t exp_data [$];
  int   test_errors  = 0;
  int   error_count  = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  logic halt_seen    = 1'b0;
  logic in_reset     = 1'b0;

  // Accepted writes and the halt level, sampled on the rising edge
  always @(posedge CLK) begin
    if (!nRST) begin
      halt_seen = 1'b0;
      // Reset values once reset has been held for a whole cycle
      if (in_reset) begin
        compare_value("imemaddr_o", 32'h0000_0000, imemaddr_i);
        compare_value("dmemren_o", 32'd0, {31'd0, dmemren_i});
        compare_value("dmemwen_o", 32'd0, {31'd0, dmemwen_i});
        compare_value("halt_o", 32'd0, {31'd0, halt_i});
      end
      in_reset = 1'b1;
    end else begin
      in_reset = 1'b0;
      if (dmemwen_i && dhit_i) begin
        if (halt_i) begin
          $display("Store to address %h seen after halt at %0t ns", dmemaddr_i, $time);
          test_errors++;
        end
        got_addr.push_back(dmemaddr_i);
        got_data.push_back(dmemstore_i);
      end
      if (halt_seen && !halt_i) begin
        $display("halt_o fell without a reset at %0t ns", $time);
        test_errors++;
      end
      if (halt_i) begin
        halt_seen = 1'b1;
      end
    end
  end

  task automatic begin_test();
    got_addr.delete();
    got_data.delete();
    exp_addr.delete();
    exp_data.delete();
    test_errors = 0;
  endtask

  task automatic expect_store(input mips_types_pkg::word_t addr,
                              input mips_types_pkg::word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic compare_value(input string name, input mips_types_pkg::word_t exp,
                               input mips_types_pkg::word_t got);
    if (exp !== got) begin
      $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
      test_errors++;
    end
  endtask

  task automatic finish_test(input int idx, input string name, input bit timed_out);
    int n;
    if (timed_out) begin
      $display("Test %0d timed out waiting for halt", idx);
      test_errors++;
    end
    if (got_addr.size() != exp_addr.size()) begin
      $display("Test %0d made %0d stores where %0d were expected",
               idx, got_addr.size(), exp_addr.size());
      test_errors++;
    end
    n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
    for (int k = 0; k < n; k++) begin
      compare_value("dmemaddr_o", exp_addr[k], got_addr[k]);
      compare_value("dmemstore_o", exp_data[k], got_data[k]);
    end
    tests_run++;
    error_count += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d stores, %0d errors", idx, name,
             (test_errors == 0) ? "passed" : "failed", got_addr.size(), test_errors);
  endtask

  task automatic report_totals();
    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, error_count);
  endtask

endmodule

`default_nettype wire

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;

  localparam int NTESTS = 5;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] FN_SLL   = 6'h00;
  localparam logic [5:0] FN_JR    = 6'h08;
  localparam logic [5:0] FN_ADDU  = 6'h21;
  localparam logic [5:0] FN_SUBU  = 6'h23;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_SLT   = 6'h2a;
  localparam logic [31:0] HALT_W  = 32'hfc00_0000;

  logic CLK;
  logic nRST;
  logic ihit_i;
  logic dhit_i;
  mips_types_pkg::word_t imemload_i, dmemload_i;
  mips_types_pkg::word_t imemaddr_o, dmemaddr_o, dmemstore_o;
  logic dmemren_o, dmemwen_o, halt_o;

  mips_types_pkg::word_t imem [64];
  mips_types_pkg::word_t dmem [64];
  int iwait, dwait;

  // Program table, one row per test
  mips_types_pkg::word_t prog [NTESTS][16];
  mips_types_pkg::word_t exp_addr [NTESTS][4];
  mips_types_pkg::word_t exp_data [NTESTS][4];
  int    exp_count [NTESTS];
  string names [NTESTS];

  mips_core mips_core_i (
    .CLK, .nRST, .imemload_i, .ihit_i, .dmemload_i, .dhit_i, .imemaddr_o,
    .dmemaddr_o, .dmemstore_o, .dmemren_o, .dmemwen_o, .halt_o
  );

  mips_checker checker_i (
    .CLK, .nRST, .dmemwen_i(dmemwen_o), .dmemren_i(dmemren_o), .dhit_i,
    .imemaddr_i(imemaddr_o), .dmemaddr_i(dmemaddr_o), .dmemstore_i(dmemstore_o),
    .halt_i(halt_o)
  );

  always #5 CLK = ~CLK;

  // Instruction memory, 0 to 3 wait states per fetch
  always @(posedge CLK) begin
    #1;
    if (!nRST) begin
      ihit_i = 1'b0;
      iwait  = -1;
    end else begin
      if (iwait < 0) begin
        iwait = $urandom % 4;
      end
      if (iwait == 0) begin
        imemload_i = imem[imemaddr_o[7:2]];
        ihit_i     = 1'b1;
        iwait      = -1;
      end else begin
        ihit_i = 1'b0;
        iwait--;
      end
    end
  end

  // Data memory
  always @(posedge CLK) begin
    #1;
    if (!nRST || !(dmemren_o || dmemwen_o)) begin
      dhit_i = 1'b0;
      dwait  = -1;
    end else begin
      if (dwait < 0) begin
        dwait = $urandom % 4;
      end
      if (dwait == 0) begin
        if (dmemwen_o) begin
          dmem[dmemaddr_o[7:2]] = dmemstore_o;
        end else begin
          dmemload_i = dmem[dmemaddr_o[7:2]];
        end
        dhit_i = 1'b1;
        dwait  = -1;
      end else begin
        dhit_i = 1'b0;
        dwait--;
      end
    end
  end

  function automatic mips_types_pkg::word_t r_type(input int rs, input int rt, input int rd,
                                                   input int sh, input logic [5:0] fn);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic mips_types_pkg::word_t i_type(input logic [5:0] op, input int rs,
                                                   input int rt, input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic mips_types_pkg::word_t j_type(input logic [5:0] op, input int target);
    return {op, target[25:0]};
  endfunction

  task automatic set_store(input int t, input int k, input mips_types_pkg::word_t addr,
                           input mips_types_pkg::word_t data);
    exp_addr[t][k] = addr;
    exp_data[t][k] = data;
    exp_count[t]   = k + 1;
  endtask

  task automatic build_table();
    foreach (prog[t, i]) begin
      prog[t][i] = '0;
    end
    // Dependent ALU and immediate chain
    names[0] = "alu_forwarding";
    prog[0] = '{i_type(OP_ADDIU, 0, 1, 16'd5), i_type(OP_ADDIU, 1, 2, 16'hfffd),
                r_type(1, 2, 3, 0, FN_SUBU), i_type(OP_SW, 0, 3, 16'd0),
                i_type(OP_LUI, 0, 4, 16'h1234), i_type(OP_ORI, 4, 4, 16'h5678),
                i_type(OP_SW, 0, 4, 16'd4), r_type(2, 1, 5, 0, FN_SLT),
                r_type(0, 4, 6, 4, FN_SLL), r_type(5, 6, 7, 0, FN_OR),
                i_type(OP_SW, 0, 7, 16'd8), i_type(OP_ADDIU, 0, 8, 16'hffff),
                r_type(8, 0, 9, 0, FN_SLT), r_type(9, 7, 10, 0, FN_AND),
                i_type(OP_SW, 0, 10, 16'd12), HALT_W};
    set_store(0, 0, 32'd0, 32'd3);
    set_store(0, 1, 32'd4, 32'h1234_5678);
    set_store(0, 2, 32'd8, 32'h2345_6781);
    set_store(0, 3, 32'd12, 32'd1);
    // Load followed by an immediate use
    names[1] = "load_use";
    prog[1][0] = i_type(OP_ADDIU, 0, 1, 16'h77);
    prog[1][1] = i_type(OP_SW, 0, 1, 16'd16);
    prog[1][2] = i_type(OP_LW, 0, 2, 16'd16);
    prog[1][3] = i_type(OP_ADDIU, 2, 3, 16'd1);
    prog[1][4] = i_type(OP_SW, 0, 3, 16'd20);
    prog[1][5] = i_type(OP_LW, 0, 4, 16'd20);
    prog[1][6] = i_type(OP_SW, 0, 4, 16'd24);
    prog[1][7] = HALT_W;
    set_store(1, 0, 32'd16, 32'h77);
    set_store(1, 1, 32'd20, 32'h78);
    set_store(1, 2, 32'd24, 32'h78);
    // Taken branches skip stores, untaken ones fall through
    names[2] = "branches";
    prog[2] = '{i_type(OP_ADDIU, 0, 1, 16'd7), i_type(OP_ADDIU, 0, 2, 16'd7),
                i_type(OP_BEQ, 1, 2, 16'd2), i_type(OP_SW, 0, 1, 16'd32),
                i_type(OP_SW, 0, 1, 16'd36), i_type(OP_BNE, 1, 0, 16'd1),
                i_type(OP_SW, 0, 2, 16'd40), j_type(OP_J, 10),
                i_type(OP_SW, 0, 1, 16'd44), i_type(OP_SW, 0, 1, 16'd48),
                i_type(OP_BEQ, 1, 0, 16'd1), i_type(OP_SW, 0, 1, 16'd52),
                i_type(OP_BNE, 1, 2, 16'd1), i_type(OP_SW, 0, 2, 16'd56),
                HALT_W, 32'd0};
    set_store(2, 0, 32'd52, 32'd7);
    set_store(2, 1, 32'd56, 32'd7);
    // Call and return
    names[3] = "jal_jr";
    prog[3][0] = i_type(OP_ADDIU, 0, 1, 16'd3);
    prog[3][1] = j_type(OP_JAL, 5);
    prog[3][2] = i_type(OP_SW, 0, 1, 16'd0);
    prog[3][3] = HALT_W;
    prog[3][4] = i_type(OP_SW, 0, 1, 16'd60);
    prog[3][5] = i_type(OP_SW, 0, 31, 16'd4);
    prog[3][6] = i_type(OP_ADDIU, 1, 1, 16'd10);
    prog[3][7] = r_type(31, 0, 0, 0, FN_JR);
    prog[3][8] = i_type(OP_SW, 0, 1, 16'd8);
    set_store(3, 0, 32'd4, 32'd8);
    set_store(3, 1, 32'd0, 32'd13);
    // Backward branch loop, three iterations
    names[4] = "loop";
    prog[4][0] = i_type(OP_ADDIU, 0, 1, 16'd0);
    prog[4][1] = i_type(OP_ADDIU, 0, 2, 16'd3);
    prog[4][2] = i_type(OP_SW, 1, 2, 16'd0);
    prog[4][3] = i_type(OP_ADDIU, 1, 1, 16'd4);
    prog[4][4] = i_type(OP_ADDIU, 2, 2, 16'hffff);
    prog[4][5] = i_type(OP_BNE, 2, 0, 16'hfffc);
    prog[4][6] = HALT_W;
    set_store(4, 0, 32'd0, 32'd3);
    set_store(4, 1, 32'd4, 32'd2);
    set_store(4, 2, 32'd8, 32'd1);
  endtask

  task automatic load_program(input int t);
    foreach (imem[i]) begin
      imem[i] = (i < 16) ? prog[t][i] : 32'd0;
    end
    foreach (dmem[i]) begin
      dmem[i] = '0;
    end
  endtask

  task automatic wait_for_halt(output bit timed_out);
    int cycles;
    cycles = 0;
    while (!halt_o && cycles < 3000) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    timed_out = !halt_o;
  endtask

  initial begin
    bit timed_out;
    int seed;
    CLK        = 1'b0;
    nRST       = 1'b0;
    ihit_i     = 1'b0;
    dhit_i     = 1'b0;
    imemload_i = '0;
    dmemload_i = '0;
    seed = $urandom(32'h01cb2585);
    build_table();
    for (int t = 0; t < NTESTS; t++) begin
      @(posedge CLK);
      #1;
      nRST = 1'b0;
      checker_i.begin_test();
      for (int k = 0; k < exp_count[t]; k++) begin
        checker_i.expect_store(exp_addr[t][k], exp_data[t][k]);
      end
      load_program(t);
      repeat (3) @(posedge CLK);
      #1;
      nRST = 1'b1;
      wait_for_halt(timed_out);
      // A few more cycles to catch stray stores after halt
      if (!timed_out) begin
        repeat (8) @(posedge CLK);
        #1;
      end
      checker_i.finish_test(t, names[t], timed_out);
    end
    checker_i.report_totals();
    if (checker_i.error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
